//--- list.f
hdl/fb_pkg.sv
hdl/display_timing.sv
hdl/render_rects.sv
hdl/bitmap_addr.sv
hdl/framebuffer_ram.sv
hdl/line_scaler.sv
hdl/clut_apb.sv
hdl/fb_display_top.sv
tb/tb_fb_display.sv

//--- run_sim.sh
#!/bin/sh
# build and run the framebuffer display testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_fb_display \
    -f list.f -o sim_fb_display
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_fb_display > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

exit 0

//--- tb/tb_fb_display.sv
/*
 * testbench for the framebuffer display top
 * APB palette load, reference frame model, per-pixel video checks
 */

`default_nettype none
`timescale 1ns/10ps

module tb_fb_display;
    import fb_pkg::*;

    localparam int H_ACTIVE = 64, H_FP = 4, H_SYNC = 8, H_BP = 4;
    localparam int V_ACTIVE = 48, V_FP = 2, V_SYNC = 2, V_BP = 2;
    localparam int FB_WIDTH = 32, FB_HEIGHT = 16;
    localparam int FB_SCALE = 2, FB_OFFY = 8, RECT_COUNT = 4;
    localparam int FRAME_CYCLES = (H_ACTIVE + H_FP + H_SYNC + H_BP)
        * (V_ACTIVE + V_FP + V_SYNC + V_BP);
    localparam int APB_LIMIT = 8;  // access phase cycles before giving up
    localparam int LIVE_IDX  = 2;  // entry rewritten between frames

    logic     clk_sys = 1'b0;
    logic     rst_sys;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    video_t   video;
    logic     draw_done;

    logic [11:0] pal_tab [16];  // palette stimulus and expected read-back
    cidx_t       ref_fb [FB_HEIGHT][FB_WIDTH];  // expected framebuffer
    logic [31:0] rnd_state;

    fb_display_top #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_SCALE(FB_SCALE),
        .FB_OFFY(FB_OFFY), .RECT_COUNT(RECT_COUNT)
    ) uut (
        .clk_sys, .rst_sys, .apb_req, .apb_rsp, .video, .draw_done
    );

    always #5 clk_sys = ~clk_sys;  // 100 MHz

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s, got %h expected %h", $time, what, actual, expected);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("Test FAILED");
        $fatal(1, "wait timed out");
    endtask

    // clipped plot into the model
    task automatic plot_ref(input int x, input int y, input cidx_t c);
        if (x >= 0 && x < FB_WIDTH && y >= 0 && y < FB_HEIGHT) ref_fb[y][x] = c;
    endtask

    // nested outlines where later rects win
    task automatic build_reference();
        int    x0, y0, x1, y1;
        cidx_t c;
        for (int y = 0; y < FB_HEIGHT; y++) begin
            for (int x = 0; x < FB_WIDTH; x++) ref_fb[y][x] = '0;
        end
        for (int k = 0; k < RECT_COUNT; k++) begin
            x0 = 4 * k - 2;
            y0 = 2 * k;
            x1 = FB_WIDTH - 1 - 2 * k;
            y1 = FB_HEIGHT - 1 - 2 * k;
            c  = cidx_t'(k + 1);
            for (int x = x0; x <= x1; x++) begin
                plot_ref(x, y0, c);  // top
                plot_ref(x, y1, c);  // bottom
            end
            for (int y = y0; y <= y1; y++) begin
                plot_ref(x0, y, c);  // left edge off screen for rect 0
                plot_ref(x1, y, c);
            end
        end
    endtask

    // colour for active pixel (x, y) and black outside the framebuffer area
    function automatic logic [11:0] expected_rgb(input int x, input int y);
        int fx, fy;
        fx = x / FB_SCALE;
        fy = (y - FB_OFFY) / FB_SCALE;
        if (y < FB_OFFY || y >= FB_OFFY + FB_HEIGHT * FB_SCALE) return '0;
        if (x >= FB_WIDTH * FB_SCALE) return '0;
        return pal_tab[ref_fb[fy][fx]];
    endfunction

    // one APB transfer of setup then access phase
    task automatic apb_transfer(input logic wr, input logic [3:0] addr,
                                input logic [11:0] wdata, output logic [11:0] rdata);
        int access_cycles;
        @(posedge clk_sys);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk_sys);
        apb_req.penable <= 1'b1;
        @(negedge clk_sys);
        access_cycles = 1;
        while (!apb_rsp.pready) begin
            if (access_cycles >= APB_LIMIT) report_timeout("APB pready");
            @(negedge clk_sys);
            access_cycles++;
        end
        rdata = apb_rsp.prdata;  // valid in access phase
        check_value(access_cycles, 1, "APB access phase length");
        check_value(apb_rsp.pslverr, 0, "APB pslverr");
        @(posedge clk_sys);
        apb_req <= '0;  // transfer completes on this edge
    endtask

    task automatic wait_vsync(input logic level);
        int n;
        n = 0;
        @(negedge clk_sys);
        while (video.vsync !== level) begin
            n++;
            if (n > FRAME_CYCLES) report_timeout("vsync level change");
            @(negedge clk_sys);
        end
    endtask

    // position taken from the video output alone
    task automatic scan_frame();
        int          x, y, de_cnt, n;
        logic [11:0] exp_rgb;
        wait_vsync(1'b0);
        wait_vsync(1'b1);  // back porch then line 0
        x      = 0;
        y      = 0;
        de_cnt = 0;
        n      = 0;
        @(negedge clk_sys);
        while (video.vsync) begin
            if (video.de) begin
                exp_rgb = expected_rgb(x, y);
                check_value(video.rgb, exp_rgb, $sformatf("rgb at pixel (%0d,%0d)", x, y));
                de_cnt++;
                x++;
                if (x == H_ACTIVE) begin  // next line
                    x = 0;
                    y++;
                end
            end else begin
                check_value(video.rgb, 0, "rgb while de low");
            end
            n++;
            if (n > FRAME_CYCLES) report_timeout("end of frame");
            @(negedge clk_sys);
        end
        check_value(de_cnt, H_ACTIVE * V_ACTIVE, "de cycles per frame");
    endtask

    initial begin
        logic [11:0] rd;
        int          n;
        rst_sys   = 1'b1;
        apb_req   = '0;
        rnd_state = 32'hc365817e;
        for (int i = 0; i < 16; i++) begin
            rnd_state  = lcg_next(rnd_state);
            pal_tab[i] = rnd_state[27:16];  // upper bits spread better
        end
        build_reference();

        repeat (3) @(posedge clk_sys);
        rst_sys <= 1'b0;

        @(negedge clk_sys);
        check_value(video.de, 0, "de after reset");
        check_value(video.hsync, 1, "hsync after reset");
        check_value(video.vsync, 1, "vsync after reset");
        check_value(video.rgb, 0, "rgb after reset");
        check_value(draw_done, 0, "draw_done before first frame");

        // palette load and read-back
        for (int i = 0; i < 16; i++) begin
            apb_transfer(1'b1, 4'(i), pal_tab[i], rd);
        end
        for (int i = 0; i < 16; i++) begin
            apb_transfer(1'b0, 4'(i), 12'h000, rd);
            check_value(rd, pal_tab[i], $sformatf("palette read-back entry %0d", i));
        end

        n = 0;
        @(negedge clk_sys);  // sample away from the clock edge
        while (draw_done !== 1'b1) begin
            n++;
            if (n > 2 * FRAME_CYCLES) report_timeout("draw_done after reset");
            @(negedge clk_sys);
        end

        // image checked on three frames in a row
        for (int f = 0; f < 3; f++) begin
            scan_frame();
        end

        // new colour during vertical blanking
        pal_tab[LIVE_IDX] = pal_tab[LIVE_IDX] ^ 12'hfff;
        apb_transfer(1'b1, 4'(LIVE_IDX), pal_tab[LIVE_IDX], rd);
        scan_frame();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/fb_display_top.sv
/*
 * framebuffer display top: renderer, address stage, RAM, line scaler,
 * APB palette and registered video output
 */

`default_nettype none
`timescale 1ns/10ps

module fb_display_top #(
    parameter int H_ACTIVE = 64, parameter int H_FP = 4,
    parameter int H_SYNC = 8, parameter int H_BP = 4,
    parameter int V_ACTIVE = 48, parameter int V_FP = 2,
    parameter int V_SYNC = 2, parameter int V_BP = 2,
    parameter int FB_WIDTH = 32, parameter int FB_HEIGHT = 16,
    parameter int FB_SCALE = 2, parameter int FB_OFFY = 8,
    parameter int RECT_COUNT = 4
) (
    input  wire logic             clk_sys,
    input  wire logic             rst_sys,
    input  wire fb_pkg::apb_req_t apb_req,
    output fb_pkg::apb_rsp_t      apb_rsp,
    output fb_pkg::video_t        video,
    output logic                  draw_done
);
    import fb_pkg::*;

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);
    localparam video_t VID_IDLE = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0, rgb: '0};

    coord_t              sx, sy;
    logic                hsync, vsync, de, frame, line;
    draw_pix_t           dpix;
    logic                drawing, clip, fb_we;
    logic [2:0]          we_sr;  // matches bitmap_addr latency
    logic [FB_ADDRW-1:0] fb_addr_write, fb_addr_read;
    cidx_t               fb_colr_write, fb_colr_read, lb_cidx;
    rgb_t                clut_rgb;
    logic                area;
    video_t              vid_now, vid_d1, vid_d2;

    display_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) timing_inst (
        .clk_sys, .rst_sys, .sx, .sy, .hsync, .vsync, .de, .frame, .line
    );

    render_rects #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .RECT_COUNT(RECT_COUNT)
    ) render_inst (
        .clk_sys, .rst_sys, .start(frame), .pix(dpix), .drawing, .done(draw_done)
    );

    bitmap_addr #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .ADDRW(FB_ADDRW)
    ) addr_inst (
        .clk_sys, .pix(dpix), .addr(fb_addr_write), .cidx(fb_colr_write), .clip
    );

    always_ff @(posedge clk_sys) begin
        we_sr <= {drawing, we_sr[2:1]};
        if (rst_sys) we_sr <= '0;
    end
    assign fb_we = we_sr[0] && !clip;  // drop clipped pixels

    framebuffer_ram #(.WIDTH(CIDXW), .DEPTH(FB_PIXELS)) fb_inst (
        .clk_sys, .we(fb_we), .addr_write(fb_addr_write), .data_in(fb_colr_write),
        .addr_read(fb_addr_read), .data_out(fb_colr_read)
    );

    line_scaler #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_SCALE(FB_SCALE),
        .FB_OFFY(FB_OFFY), .ADDRW(FB_ADDRW)
    ) scaler_inst (
        .clk_sys, .rst_sys, .frame, .line, .sy, .sx,
        .fb_addr(fb_addr_read), .fb_data(fb_colr_read), .cidx(lb_cidx)
    );

    // clut output already lines up with the current sx
    clut_apb clut_inst (
        .clk_sys, .rst_sys, .apb_req, .apb_rsp, .cidx(lb_cidx), .rgb(clut_rgb)
    );

    always_comb begin
        area = (sy >= FB_OFFY && sy < FB_OFFY + FB_HEIGHT * FB_SCALE
            && sx >= 0 && sx < FB_WIDTH * FB_SCALE);
        vid_now.hsync = hsync;
        vid_now.vsync = vsync;
        vid_now.de    = de;
        vid_now.rgb   = (de && area) ? clut_rgb : '0;  // black in blanking
    end

    // 3 register stages to the pins
    always_ff @(posedge clk_sys) begin
        vid_d1 <= vid_now;
        vid_d2 <= vid_d1;
        video  <= vid_d2;
        if (rst_sys) begin
            vid_d1 <= VID_IDLE;
            vid_d2 <= VID_IDLE;
            video  <= VID_IDLE;
        end
    end

endmodule

`default_nettype wire

//--- hdl/clut_apb.sv
/*
 * 16-entry colour lookup table
 * APB slave for palette write and read-back, registered lookup port
 */

`default_nettype none
`timescale 1ns/10ps

module clut_apb (
    input  wire logic             clk_sys,
    input  wire logic             rst_sys,
    input  wire fb_pkg::apb_req_t apb_req,
    output fb_pkg::apb_rsp_t      apb_rsp,
    input  wire fb_pkg::cidx_t    cidx,
    output fb_pkg::rgb_t          rgb
);
    import fb_pkg::*;

    rgb_t        pal [16];
    logic [11:0] rd_data;
    logic        setup_rd, access_wr;

    always_comb begin
        setup_rd  = apb_req.psel && !apb_req.penable && !apb_req.pwrite;
        access_wr = apb_req.psel && apb_req.penable && apb_req.pwrite;
        apb_rsp.pready  = 1'b1;  // zero wait states
        apb_rsp.prdata  = rd_data;
        apb_rsp.pslverr = 1'b0;
    end

    always_ff @(posedge clk_sys) begin
        if (access_wr) pal[apb_req.paddr] <= rgb_t'(apb_req.pwdata);
        if (setup_rd) rd_data <= pal[apb_req.paddr];  // ready for access phase
        rgb <= pal[cidx];  // video lookup
        if (rst_sys) begin
            rd_data <= '0;
            rgb     <= '0;
            for (int i = 0; i < 16; i++) begin
                pal[i] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/line_scaler.sv
/*
 * line scaler, fetches each framebuffer row into a ping-pong line buffer
 * and replays it with pixels and lines repeated FB_SCALE times
 */

`default_nettype none
`timescale 1ns/10ps

module line_scaler #(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 16,
    parameter int FB_SCALE  = 2,
    parameter int FB_OFFY   = 8,
    parameter int ADDRW     = 9
) (
    input  wire logic             clk_sys,
    input  wire logic             rst_sys,
    input  wire logic             frame,
    input  wire logic             line,
    input  wire fb_pkg::coord_t   sy,
    input  wire fb_pkg::coord_t   sx,
    output logic      [ADDRW-1:0] fb_addr,
    input  wire fb_pkg::cidx_t    fb_data,
    output fb_pkg::cidx_t         cidx
);
    import fb_pkg::*;

    localparam int SUBW  = $clog2(FB_SCALE) + 1;
    localparam int XW    = $clog2(FB_WIDTH) + 1;
    localparam int LBW   = $clog2(2 * FB_WIDTH);
    localparam int Y_END = FB_OFFY + FB_HEIGHT * FB_SCALE;  // first row past area

    cidx_t           lbuf [2 * FB_WIDTH];
    logic [SUBW-1:0] sub, new_sub;  // line phase in scale group
    logic            ld_line, ld_next;  // this line fetches the next row
    logic [XW-1:0]   cnt_lbx;
    logic            fetch, wr_en;
    logic [XW-1:0]   wr_idx;
    logic            wr_half, rd_half;
    coord_t          xa;  // lookahead, lbuf + clut
    logic            rd_area, rd_en;
    cidx_t           lb_q;

    always_comb begin
        new_sub = (sy == FB_OFFY || sub == SUBW'(FB_SCALE - 1)) ? '0 : sub + 1'b1;
        ld_next = (sy >= FB_OFFY - 1) && (sy < Y_END - 1)
            && (sy == FB_OFFY - 1 || new_sub == SUBW'(FB_SCALE - 1));
        fetch   = ld_line && (cnt_lbx < XW'(FB_WIDTH));
        xa      = sx + 2;
        rd_area = (sy >= FB_OFFY && sy < Y_END && xa >= 0 && xa < FB_WIDTH * FB_SCALE);
        cidx    = rd_en ? lb_q : '0;  // black outside the area
    end

    always_ff @(posedge clk_sys) begin
        if (line) begin
            sub     <= new_sub;
            ld_line <= ld_next;
            cnt_lbx <= '0;
            if (ld_line) begin  // row just fetched becomes visible
                rd_half <= wr_half;
                wr_half <= ~wr_half;
            end
        end else if (fetch) begin
            fb_addr <= fb_addr + 1'b1;
            cnt_lbx <= cnt_lbx + 1'b1;
        end
        wr_en  <= fetch;  // ram data lands a cycle later
        wr_idx <= cnt_lbx;
        rd_en  <= rd_area;
        if (frame) fb_addr <= '0;
        if (rst_sys) begin
            sub     <= '0;
            ld_line <= 1'b0;
            cnt_lbx <= '0;
            fb_addr <= '0;
            wr_en   <= 1'b0;
            wr_half <= 1'b0;
            rd_half <= 1'b0;
            rd_en   <= 1'b0;
        end
    end

    // line buffer, no reset
    always_ff @(posedge clk_sys) begin
        if (wr_en) lbuf[LBW'(wr_half * FB_WIDTH) + LBW'(wr_idx)] <= fb_data;
        lb_q <= lbuf[LBW'(rd_half * FB_WIDTH) + LBW'($unsigned(xa) / FB_SCALE)];
    end

endmodule

`default_nettype wire

//--- hdl/framebuffer_ram.sv
/*
 * simple dual-port RAM, one write port and one registered read port
 */

`default_nettype none
`timescale 1ns/10ps

module framebuffer_ram #(
    parameter int WIDTH = 4,
    parameter int DEPTH = 512,
    parameter int ADDRW = $clog2(DEPTH)
) (
    input  wire logic             clk_sys,
    input  wire logic             we,
    input  wire logic [ADDRW-1:0] addr_write,
    input  wire logic [WIDTH-1:0] data_in,
    input  wire logic [ADDRW-1:0] addr_read,
    output logic      [WIDTH-1:0] data_out
);

    logic [WIDTH-1:0] mem [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;  // blank picture at power-up
        end
    end

    always_ff @(posedge clk_sys) begin
        if (we) mem[addr_write] <= data_in;
        data_out <= mem[addr_read];  // 1 cycle read
    end

endmodule

`default_nettype wire

//--- hdl/bitmap_addr.sv
/*
 * bitmap address pipeline
 * draw coordinates to linear framebuffer address plus clip, 3 cycles
 */

`default_nettype none
`timescale 1ns/10ps

module bitmap_addr #(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 16,
    parameter int ADDRW     = 9
) (
    input  wire logic              clk_sys,
    input  wire fb_pkg::draw_pix_t pix,
    output logic [ADDRW-1:0]       addr,
    output fb_pkg::cidx_t          cidx,
    output logic                   clip
);
    import fb_pkg::*;

    coord_t           x1, y1, x2;
    cidx_t            cidx1, cidx2;
    logic             clip1, clip2;
    logic [ADDRW-1:0] row2;  // y * width

    always_ff @(posedge clk_sys) begin
        // stage 1: bounds
        clip1 <= (pix.x < 0 || pix.x >= FB_WIDTH || pix.y < 0 || pix.y >= FB_HEIGHT);
        x1    <= pix.x;
        y1    <= pix.y;
        cidx1 <= pix.cidx;
        // stage 2: row start
        row2  <= ADDRW'(y1 * FB_WIDTH);
        x2    <= x1;
        cidx2 <= cidx1;
        clip2 <= clip1;
        // stage 3: add column
        addr  <= row2 + ADDRW'(x2);
        cidx  <= cidx2;
        clip  <= clip2;
    end

endmodule

`default_nettype wire

//--- hdl/render_rects.sv
/*
 * nested rectangle renderer
 * one outline pixel per cycle, restarted by a start strobe
 */

`default_nettype none
`timescale 1ns/10ps

module render_rects #(
    parameter int FB_WIDTH   = 32,
    parameter int FB_HEIGHT  = 16,
    parameter int RECT_COUNT = 4
) (
    input  wire logic         clk_sys,
    input  wire logic         rst_sys,
    input  wire logic         start,
    output fb_pkg::draw_pix_t pix,
    output logic              drawing,
    output logic              done
);
    import fb_pkg::*;

    typedef enum logic [1:0] {IDLE, DRAW, DONE} state_t;
    state_t state;

    coord_t     rk;      // current rectangle
    logic [1:0] edge_n;  // 0 top, 1 bottom, 2 left, 3 right
    coord_t     x, y;
    coord_t     x0, y0, x1, y1;

    // corners of rectangle rk, rect 0 hangs off the left edge
    always_comb begin
        x0 = (rk <<< 2) - 2;
        y0 = rk <<< 1;
        x1 = coord_t'(FB_WIDTH - 1) - (rk <<< 1);
        y1 = coord_t'(FB_HEIGHT - 1) - (rk <<< 1);
    end

    always_comb begin
        pix.x    = x;
        pix.y    = y;
        pix.cidx = cidx_t'(rk + 1);  // colour k+1
        drawing  = (state == DRAW);
        done     = (state == DONE);
    end

    always_ff @(posedge clk_sys) begin
        case (state)
            IDLE, DONE: if (start) begin
                state  <= DRAW;
                rk     <= '0;
                edge_n <= 2'd0;
                x      <= -2;  // corner of rect 0
                y      <= '0;
            end
            DRAW: begin
                if (edge_n[1] == 1'b0) begin  // horizontal edges
                    if (x == x1) begin
                        edge_n <= edge_n + 1'b1;
                        x <= x0;
                        y <= (edge_n == 2'd0) ? y1 : y0;  // bottom, then left
                    end else begin
                        x <= x + 1'b1;
                    end
                end else if (y != y1) begin  // vertical edges
                    y <= y + 1'b1;
                end else if (edge_n == 2'd2) begin
                    edge_n <= 2'd3;
                    x <= x1;
                    y <= y0;
                end else if (rk == coord_t'(RECT_COUNT - 1)) begin
                    state <= DONE;  // last pixel of last rect
                end else begin
                    rk     <= rk + 1'b1;
                    edge_n <= 2'd0;
                    x      <= ((rk + 1'b1) <<< 2) - 2;  // next rect corner
                    y      <= (rk + 1'b1) <<< 1;
                end
            end
            default: state <= IDLE;
        endcase
        if (rst_sys) begin
            state  <= IDLE;
            rk     <= '0;
            edge_n <= 2'd0;
            x      <= '0;
            y      <= '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/display_timing.sv
/*
 * display timing generator
 * screen position, active-low syncs, data enable, frame and line strobes
 */

`default_nettype none
`timescale 1ns/10ps

module display_timing #(
    parameter int H_ACTIVE = 64,
    parameter int H_FP     = 4,
    parameter int H_SYNC   = 8,
    parameter int H_BP     = 4,
    parameter int V_ACTIVE = 48,
    parameter int V_FP     = 2,
    parameter int V_SYNC   = 2,
    parameter int V_BP     = 2
) (
    input  wire logic     clk_sys,
    input  wire logic     rst_sys,
    output fb_pkg::coord_t sx,
    output fb_pkg::coord_t sy,
    output logic          hsync,
    output logic          vsync,
    output logic          de,
    output logic          frame,
    output logic          line
);
    import fb_pkg::*;

    // blanking sits at negative coordinates, active area starts at 0
    localparam int H_STA  = 0 - H_FP - H_SYNC - H_BP;
    localparam int HS_STA = H_STA + H_FP;
    localparam int HS_END = HS_STA + H_SYNC;
    localparam int H_END  = H_ACTIVE - 1;
    localparam int V_STA  = 0 - V_FP - V_SYNC - V_BP;
    localparam int VS_STA = V_STA + V_FP;
    localparam int VS_END = VS_STA + V_SYNC;
    localparam int V_END  = V_ACTIVE - 1;

    always_comb begin
        hsync = ~(sx >= HS_STA && sx < HS_END);  // active low
        vsync = ~(sy >= VS_STA && sy < VS_END);
        de    = (sx >= 0 && sy >= 0);
        frame = (sy == V_STA && sx == H_STA);  // blanking ahead of line 0
        line  = (sx == H_STA);
    end

    always_ff @(posedge clk_sys) begin
        if (sx == H_END) begin  // end of line
            sx <= coord_t'(H_STA);
            sy <= (sy == V_END) ? coord_t'(V_STA) : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
        if (rst_sys) begin
            sx <= coord_t'(H_STA);
            sy <= coord_t'(V_STA);
        end
    end

endmodule

`default_nettype wire

//--- hdl/fb_pkg.sv
/*
 * framebuffer graphics types
 * coordinates, colours, draw pixels, APB and video buses
 */

`default_nettype none

package fb_pkg;

    localparam int CORDW = 16;  // signed coordinate width
    localparam int CIDXW = 4;   // colour index width
    localparam int CHANW = 4;   // bits per colour channel

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [CIDXW-1:0] cidx_t;

    typedef struct packed {
        logic [CHANW-1:0] r;
        logic [CHANW-1:0] g;
        logic [CHANW-1:0] b;
    } rgb_t;

    // one pixel from the renderer, 36 bits
    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } draw_pix_t;

    // master side, paddr picks the palette entry
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [11:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [11:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic hsync;  // active low
        logic vsync;  // active low
        logic de;
        rgb_t rgb;
    } video_t;

endpackage

`default_nettype wire
